//--- logic/fifo_config.svh
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// storage geometry
// depth must stay a power of two
`define FIFO_DEPTH 16
`define FIFO_ADDR_W 4

// extra msb separates full from empty
`define FIFO_PTR_W 5

// static almost-full / almost-empty levels
`define FIFO_AFULL_VAL 12
`define FIFO_AEMPTY_VAL 4

`endif

//--- logic/fifo_pkg.sv
`default_nettype none

`include "fifo_config.svh"

package fifo_pkg;

   // ----------------------------------------------------------------------
   // basic scalar types
   // ----------------------------------------------------------------------

   // pointer or occupancy count one bit wider than the address
   typedef logic [`FIFO_PTR_W-1:0] ptr_t;

   // address into the two-port memory
   typedef logic [`FIFO_ADDR_W-1:0] addr_t;

   // ----------------------------------------------------------------------
   // status bundles with all fields registered
   // ----------------------------------------------------------------------

   // write side flags and count
   typedef struct packed {
      logic full;
      logic afull;
      logic wack;
      logic overflow;
      ptr_t wrcnt;
   } wr_status_t;

   // read side flags and count
   typedef struct packed {
      logic empty;
      logic aempty;
      logic dvld;
      logic underflow;
      ptr_t rdcnt;
   } rd_status_t;

   // ----------------------------------------------------------------------
   // memory port bundles
   // ----------------------------------------------------------------------

   // enables are combinational
   typedef struct packed {
      addr_t waddr;
      logic  we;
   } wr_mem_t;

   typedef struct packed {
      addr_t raddr;
      logic  re;
   } rd_mem_t;

endpackage

`default_nettype wire

//--- logic/fifo_wr_side.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_config.svh"

// write half of the FIFO controller
// owns the write pointer and all write-domain status

module fifo_wr_side (
   input  wire logic                pos_clk,
   input  wire logic                aresetn,

   // write request
   input  wire logic                wr_en_i,

   // read pointer as it stood before this edge
   input  wire fifo_pkg::ptr_t      rptr_i,

   // registered write pointer for the read side
   output fifo_pkg::ptr_t           wptr_o,

   // registered write status
   output fifo_pkg::wr_status_t     wr_status_o,

   // memory write port
   output fifo_pkg::wr_mem_t        wr_mem_o
);

   // ----------------------------------------------------------------------
   // thresholds
   // ----------------------------------------------------------------------

   // occupancy at which full asserts
   localparam fifo_pkg::ptr_t FULL_LVL = fifo_pkg::ptr_t'(`FIFO_DEPTH);

   // afull set and clear boundary one below the level
   localparam fifo_pkg::ptr_t AFULL_THR = fifo_pkg::ptr_t'(`FIFO_AFULL_VAL - 1);

   // ----------------------------------------------------------------------
   // internal signals
   // ----------------------------------------------------------------------

   // write allowed this cycle
   logic           we_acc;

   // pointer after this edge
   fifo_pkg::ptr_t wptr_nxt;

   // new write pointer minus old read pointer
   fifo_pkg::ptr_t wdiff;

   // next value of the afull hysteresis
   logic           afull_nxt;

   // ----------------------------------------------------------------------
   // accept and advance
   // ----------------------------------------------------------------------

   // drop writes while full
   assign we_acc   = wr_en_i & ~wr_status_o.full;

   // wraps modulo 32 on its own
   assign wptr_nxt = wptr_o + fifo_pkg::ptr_t'(we_acc);

   // occupancy seen from the write side
   assign wdiff    = wptr_nxt - rptr_i;

   // ----------------------------------------------------------------------
   // almost-full hysteresis
   // ----------------------------------------------------------------------
   always_comb begin
      afull_nxt = wr_status_o.afull;
      // set only while writing
      if (wr_en_i && (wdiff >= AFULL_THR)) begin
         afull_nxt = 1'b1;
      end else if (wdiff <= AFULL_THR) begin
         afull_nxt = 1'b0;
      end
   end

   // ----------------------------------------------------------------------
   // pointer register
   // ----------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wptr_o <= '0;
      end else begin
         wptr_o <= wptr_nxt;
      end
   end

   // ----------------------------------------------------------------------
   // status registers
   // ----------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wr_status_o <= '0;
      end else begin
         wr_status_o.full     <= (wdiff >= FULL_LVL);
         wr_status_o.afull    <= afull_nxt;
         wr_status_o.wrcnt    <= wdiff;
         // per-cycle handshake flags
         wr_status_o.wack     <= we_acc;
         // uses full from before the edge
         wr_status_o.overflow <= wr_en_i & wr_status_o.full;
      end
   end

   // ----------------------------------------------------------------------
   // memory write port
   // ----------------------------------------------------------------------
   always_comb begin
      // address is the low part of the registered pointer
      wr_mem_o.waddr = wptr_o[`FIFO_ADDR_W-1:0];
      // same cycle as the accepted write
      wr_mem_o.we    = we_acc;
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------

   // memory is never written when the pointers are a full depth apart
   a_we_not_full : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      wr_mem_o.we |-> ((wptr_o - rptr_i) != FULL_LVL)
   ) else $error("memory write while full");

   // read pointer must never fall more than one depth behind
   a_wdiff_bound : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      wdiff <= FULL_LVL
   ) else $error("write difference above depth");

endmodule

`default_nettype wire

//--- logic/fifo_rd_side.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_config.svh"

// read half of the FIFO controller
// owns the read pointer and all read-domain status

module fifo_rd_side (
   input  wire logic                pos_clk,
   input  wire logic                aresetn,

   // read request
   input  wire logic                rd_en_i,

   // write pointer as it stood before this edge
   input  wire fifo_pkg::ptr_t      wptr_i,

   // registered read pointer for the write side
   output fifo_pkg::ptr_t           rptr_o,

   // registered read status
   output fifo_pkg::rd_status_t     rd_status_o,

   // memory read port
   output fifo_pkg::rd_mem_t        rd_mem_o
);

   // ----------------------------------------------------------------------
   // thresholds
   // ----------------------------------------------------------------------

   // aempty boundary used for both set and clear
   localparam fifo_pkg::ptr_t AEMPTY_THR = fifo_pkg::ptr_t'(`FIFO_AEMPTY_VAL);

   // largest occupancy the read side may ever see
   localparam fifo_pkg::ptr_t DEPTH_LVL = fifo_pkg::ptr_t'(`FIFO_DEPTH);

   // ----------------------------------------------------------------------
   // internal signals
   // ----------------------------------------------------------------------

   // read allowed this cycle
   logic           re_acc;

   // pointer after this edge
   fifo_pkg::ptr_t rptr_nxt;

   // old write pointer minus new read pointer
   fifo_pkg::ptr_t rdiff;

   // next value of the aempty hysteresis
   logic           aempty_nxt;

   // ----------------------------------------------------------------------
   // accept and advance
   // ----------------------------------------------------------------------

   // drop reads while empty
   assign re_acc   = rd_en_i & ~rd_status_o.empty;

   // wraps modulo 32 on its own
   assign rptr_nxt = rptr_o + fifo_pkg::ptr_t'(re_acc);

   // occupancy seen from the read side
   assign rdiff    = wptr_i - rptr_nxt;

   // ----------------------------------------------------------------------
   // almost-empty hysteresis
   // ----------------------------------------------------------------------
   always_comb begin
      aempty_nxt = rd_status_o.aempty;
      // clear wins once enough entries sit in the memory
      if (rd_status_o.aempty && (rdiff >= AEMPTY_THR)) begin
         aempty_nxt = 1'b0;
      end else if (rd_en_i && (rdiff <= AEMPTY_THR)) begin
         aempty_nxt = 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // pointer register
   // ----------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rptr_o <= '0;
      end else begin
         rptr_o <= rptr_nxt;
      end
   end

   // ----------------------------------------------------------------------
   // status registers
   // ----------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         // empty and aempty start high
         rd_status_o.empty     <= 1'b1;
         rd_status_o.aempty    <= 1'b1;
         rd_status_o.dvld      <= 1'b0;
         rd_status_o.underflow <= 1'b0;
         rd_status_o.rdcnt     <= '0;
      end else begin
         rd_status_o.empty     <= (rdiff == '0);
         rd_status_o.aempty    <= aempty_nxt;
         rd_status_o.rdcnt     <= rdiff;
         // per-cycle handshake flags
         rd_status_o.dvld      <= re_acc;
         // uses empty from before the edge
         rd_status_o.underflow <= rd_en_i & rd_status_o.empty;
      end
   end

   // ----------------------------------------------------------------------
   // memory read port
   // ----------------------------------------------------------------------
   always_comb begin
      rd_mem_o.raddr = rptr_o[`FIFO_ADDR_W-1:0];
      rd_mem_o.re    = re_acc;
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------

   // write pointer must never run more than one depth ahead
   a_rdiff_bound : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      rdiff <= DEPTH_LVL
   ) else $error("read difference above depth");

   // memory is never read when both pointers meet
   a_re_not_empty : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      rd_mem_o.re |-> (wptr_i != rptr_o)
   ) else $error("memory read while empty");

endmodule

`default_nettype wire

//--- logic/fifo_sync_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// single-clock FIFO controller for an external two-port memory
// blocks writes while full and reads while empty

module fifo_sync_ctrl (
   input  wire logic                pos_clk,
   input  wire logic                aresetn,

   // requests from the user side
   input  wire logic                wr_en_i,
   input  wire logic                rd_en_i,

   // registered status
   output fifo_pkg::wr_status_t     wr_status_o,
   output fifo_pkg::rd_status_t     rd_status_o,

   // memory address and enable lines
   output fifo_pkg::wr_mem_t        wr_mem_o,
   output fifo_pkg::rd_mem_t        rd_mem_o
);

   // ----------------------------------------------------------------------
   // pointer exchange between the two sides
   // ----------------------------------------------------------------------

   // registered write pointer, seen by the read side
   fifo_pkg::ptr_t wptr;

   // registered read pointer, seen by the write side
   fifo_pkg::ptr_t rptr;

   // ----------------------------------------------------------------------
   // write side
   // ----------------------------------------------------------------------

   // full, afull, wrcnt, wack, overflow
   // plus write address and write enable
   fifo_wr_side i_fifo_wr_side (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en_i),
      .rptr_i      (rptr),
      .wptr_o      (wptr),
      .wr_status_o (wr_status_o),
      .wr_mem_o    (wr_mem_o)
   );

   // ----------------------------------------------------------------------
   // read side
   // ----------------------------------------------------------------------

   // empty, aempty, rdcnt, dvld, underflow
   // plus read address and read enable
   fifo_rd_side i_fifo_rd_side (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .rd_en_i     (rd_en_i),
      .wptr_i      (wptr),
      .rptr_o      (rptr),
      .rd_status_o (rd_status_o),
      .rd_mem_o    (rd_mem_o)
   );

   // each side only sees the other pointer from before the edge
   // so a read in the same cycle never frees a full slot early,
   // and a write never clears empty early

endmodule

`default_nettype wire

//--- bench/tb_fifo_sync_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_sync_ctrl;

   localparam int CLK_PERIOD = 10;
   localparam int RST_CYCLES = 16;

   // one row of the vector file with enables and expected results
   typedef struct packed {
      logic                 wr;
      logic                 rd;
      fifo_pkg::wr_status_t wr_st;
      fifo_pkg::rd_status_t rd_st;
      fifo_pkg::addr_t      waddr;
      fifo_pkg::addr_t      raddr;
   } vec_t;

   logic                 pos_clk = 1'b0;
   logic                 aresetn;
   logic                 wr_en;
   logic                 rd_en;
   fifo_pkg::wr_status_t wr_status;
   fifo_pkg::rd_status_t rd_status;
   fifo_pkg::wr_mem_t    wr_mem;
   fifo_pkg::rd_mem_t    rd_mem;

   vec_t  vecs[$];
   string names[$];
   int    num_vec = 0;

   always #(CLK_PERIOD / 2) pos_clk = ~pos_clk;

   fifo_sync_ctrl i_fifo_sync_ctrl (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en),
      .rd_en_i     (rd_en),
      .wr_status_o (wr_status),
      .rd_status_o (rd_status),
      .wr_mem_o    (wr_mem),
      .rd_mem_o    (rd_mem)
   );

   // ----------------------------------------------------------------------
   // error exit and compare tasks
   // ----------------------------------------------------------------------
   task automatic stop_on_error();
      $display("Verification failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_wr_status(input string name, input fifo_pkg::wr_status_t exp,
                                  input fifo_pkg::wr_status_t act);
      if (act !== exp) begin
         $display("FAILED %s wr_status expected %03h actual %03h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_rd_status(input string name, input fifo_pkg::rd_status_t exp,
                                  input fifo_pkg::rd_status_t act);
      if (act !== exp) begin
         $display("FAILED %s rd_status expected %03h actual %03h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_addr(input string name, input string port, input fifo_pkg::addr_t exp,
                             input fifo_pkg::addr_t act);
      if (act !== exp) begin
         $display("FAILED %s %s expected %0d actual %0d", name, port, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_enable(input string name, input string port, input logic exp,
                               input logic act);
      if (act !== exp) begin
         $display("FAILED %s %s expected %b actual %b", name, port, exp, act);
         stop_on_error();
      end
   endtask

   // ----------------------------------------------------------------------
   // vector file reader
   // ----------------------------------------------------------------------
   task automatic load_vectors();
      int    fd;
      int    n;
      int    f[14];
      string line;
      string name;
      vec_t  v;
      fd = $fopen("bench/fifo_vectors.txt", "r");
      if (fd == 0) begin
         $display("cannot open vector file bench/fifo_vectors.txt");
         stop_on_error();
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         // skip comment lines and blank lines
         if (n > 0 && line.len() > 0 && line[0] != "#") begin
            n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d", name,
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                        f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
            if (n > 0 && n != 15) begin
               $display("vector file line is short or malformed: %s", line);
               stop_on_error();
            end
            if (n == 15) begin
               v.wr             = f[0][0];
               v.rd             = f[1][0];
               v.wr_st.full     = f[2][0];
               v.wr_st.afull    = f[3][0];
               v.wr_st.wack     = f[4][0];
               v.wr_st.overflow = f[5][0];
               v.wr_st.wrcnt    = fifo_pkg::ptr_t'(f[6]);
               v.rd_st.empty     = f[7][0];
               v.rd_st.aempty    = f[8][0];
               v.rd_st.dvld      = f[9][0];
               v.rd_st.underflow = f[10][0];
               v.rd_st.rdcnt     = fifo_pkg::ptr_t'(f[11]);
               v.waddr = fifo_pkg::addr_t'(f[12]);
               v.raddr = fifo_pkg::addr_t'(f[13]);
               vecs.push_back(v);
               names.push_back(name);
            end
         end
      end
      $fclose(fd);
      if (vecs.size() == 0) begin
         $display("vector file holds no test vectors");
         stop_on_error();
      end
      num_vec = vecs.size();
   endtask

   // ----------------------------------------------------------------------
   // stimulus and checking
   // ----------------------------------------------------------------------
   initial begin : main
      int   i;
      logic nxt_wr;
      logic nxt_rd;
      aresetn = 1'b0;
      wr_en   = 1'b0;
      rd_en   = 1'b0;
      load_vectors();
      repeat (RST_CYCLES) @(posedge pos_clk);
      aresetn <= 1'b1;
      wr_en   <= vecs[0].wr;
      rd_en   <= vecs[0].rd;
      for (i = 0; i < num_vec; i++) begin
         // edge that samples row i
         @(posedge pos_clk);
         if (i + 1 < num_vec) begin
            nxt_wr = vecs[i + 1].wr;
            nxt_rd = vecs[i + 1].rd;
         end else begin
            nxt_wr = 1'b0;
            nxt_rd = 1'b0;
         end
         wr_en <= nxt_wr;
         rd_en <= nxt_rd;
         // sample just before the next edge
         #(CLK_PERIOD - 1);
         check_wr_status(names[i], vecs[i].wr_st, wr_status);
         check_rd_status(names[i], vecs[i].rd_st, rd_status);
         check_addr(names[i], "waddr", vecs[i].waddr, wr_mem.waddr);
         check_addr(names[i], "raddr", vecs[i].raddr, rd_mem.raddr);
         // memory enables follow the next request gated by full and empty
         check_enable(names[i], "we", nxt_wr & ~vecs[i].wr_st.full, wr_mem.we);
         check_enable(names[i], "re", nxt_rd & ~vecs[i].rd_st.empty, rd_mem.re);
      end
      $display("Verification passed");
      $finish;
   end

   // watchdog sized from the vector count
   initial begin : watchdog
      wait (num_vec > 0);
      #((RST_CYCLES + num_vec + 20) * CLK_PERIOD);
      $display("timeout, the vectors did not finish in time");
      stop_on_error();
   end

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
logic/fifo_pkg.sv
logic/fifo_wr_side.sv
logic/fifo_rd_side.sv
logic/fifo_sync_ctrl.sv
bench/tb_fifo_sync_ctrl.sv

//--- bench/fifo_vectors.txt
# name wr rd | full afull wack ovf wrcnt | empty aempty dvld udf rdcnt | waddr raddr
# expected values hold after the clock edge that samples wr and rd
reset      0 0  0 0 0 0  0  1 1 0 0  0   0  0
fill_01    1 0  0 0 1 0  1  1 1 0 0  0   1  0
fill_02    1 0  0 0 1 0  2  0 1 0 0  1   2  0
fill_03    1 0  0 0 1 0  3  0 1 0 0  2   3  0
fill_04    1 0  0 0 1 0  4  0 1 0 0  3   4  0
fill_05    1 0  0 0 1 0  5  0 0 0 0  4   5  0
fill_06    1 0  0 0 1 0  6  0 0 0 0  5   6  0
fill_07    1 0  0 0 1 0  7  0 0 0 0  6   7  0
fill_08    1 0  0 0 1 0  8  0 0 0 0  7   8  0
fill_09    1 0  0 0 1 0  9  0 0 0 0  8   9  0
fill_10    1 0  0 0 1 0  10 0 0 0 0  9   10 0
fill_11    1 0  0 1 1 0  11 0 0 0 0  10  11 0
fill_12    1 0  0 1 1 0  12 0 0 0 0  11  12 0
fill_13    1 0  0 1 1 0  13 0 0 0 0  12  13 0
fill_14    1 0  0 1 1 0  14 0 0 0 0  13  14 0
fill_15    1 0  0 1 1 0  15 0 0 0 0  14  15 0
fill_16    1 0  1 1 1 0  16 0 0 0 0  15  0  0
ovf_1      1 0  1 1 0 1  16 0 0 0 0  16  0  0
ovf_2      1 0  1 1 0 1  16 0 0 0 0  16  0  0
idle_full  0 0  1 1 0 0  16 0 0 0 0  16  0  0
drain_01   0 1  1 1 0 0  16 0 0 1 0  15  0  1
drain_02   0 1  0 1 0 0  15 0 0 1 0  14  0  2
drain_03   0 1  0 1 0 0  14 0 0 1 0  13  0  3
drain_04   0 1  0 1 0 0  13 0 0 1 0  12  0  4
drain_05   0 1  0 1 0 0  12 0 0 1 0  11  0  5
drain_06   0 1  0 0 0 0  11 0 0 1 0  10  0  6
drain_07   0 1  0 0 0 0  10 0 0 1 0  9   0  7
drain_08   0 1  0 0 0 0  9  0 0 1 0  8   0  8
drain_09   0 1  0 0 0 0  8  0 0 1 0  7   0  9
drain_10   0 1  0 0 0 0  7  0 0 1 0  6   0  10
drain_11   0 1  0 0 0 0  6  0 0 1 0  5   0  11
drain_12   0 1  0 0 0 0  5  0 1 1 0  4   0  12
drain_13   0 1  0 0 0 0  4  0 1 1 0  3   0  13
drain_14   0 1  0 0 0 0  3  0 1 1 0  2   0  14
drain_15   0 1  0 0 0 0  2  0 1 1 0  1   0  15
drain_16   0 1  0 0 0 0  1  1 1 1 0  0   0  0
udf        0 1  0 0 0 0  0  1 1 0 1  0   0  0
idle_empty 0 0  0 0 0 0  0  1 1 0 0  0   0  0
refill_1   1 0  0 0 1 0  1  1 1 0 0  0   1  0
refill_2   1 0  0 0 1 0  2  0 1 0 0  1   2  0
refill_3   1 0  0 0 1 0  3  0 1 0 0  2   3  0
refill_4   1 0  0 0 1 0  4  0 1 0 0  3   4  0
refill_5   1 0  0 0 1 0  5  0 0 0 0  4   5  0
refill_6   1 0  0 0 1 0  6  0 0 0 0  5   6  0
refill_7   1 0  0 0 1 0  7  0 0 0 0  6   7  0
refill_8   1 0  0 0 1 0  8  0 0 0 0  7   8  0
both_1     1 1  0 0 1 0  9  0 0 1 0  7   9  1
both_2     1 1  0 0 1 0  9  0 0 1 0  7   10 2
both_3     1 1  0 0 1 0  9  0 0 1 0  7   11 3
both_4     1 1  0 0 1 0  9  0 0 1 0  7   12 4
both_5     1 1  0 0 1 0  9  0 0 1 0  7   13 5
both_6     1 1  0 0 1 0  9  0 0 1 0  7   14 6
both_7     1 1  0 0 1 0  9  0 0 1 0  7   15 7
both_8     1 1  0 0 1 0  9  0 0 1 0  7   0  8
idle_mid   0 0  0 0 0 0  8  0 0 0 0  8   0  8
wrap_1     0 1  0 0 0 0  8  0 0 1 0  7   0  9
wrap_2     0 1  0 0 0 0  7  0 0 1 0  6   0  10
wrap_3     0 1  0 0 0 0  6  0 0 1 0  5   0  11
wrap_4     0 1  0 0 0 0  5  0 1 1 0  4   0  12
wrap_5     0 1  0 0 0 0  4  0 1 1 0  3   0  13
wrap_6     0 1  0 0 0 0  3  0 1 1 0  2   0  14
wrap_7     0 1  0 0 0 0  2  0 1 1 0  1   0  15
wrap_8     0 1  0 0 0 0  1  1 1 1 0  0   0  0
idle_end   0 0  0 0 0 0  0  1 1 0 0  0   0  0
